/* bench/dcacheTb.sv */
`timescale 1ns/1ps

module dcacheTb;
    localparam int cyclesPerReq = 200;
    localparam logic [31:0] fillPattern = 32'hA5C3_0F69;
    localparam logic [1:0] anyTime = 2'd0;
    localparam logic [1:0] hitNow = 2'd1;
    localparam logic [1:0] missNow = 2'd2;

    logic CLK = 1'b0;
    logic nRST;
    busPkg::dpReq dpReqIn;
    busPkg::dpResp dpRespOut;
    busPkg::memReq memReqOut;
    busPkg::memResp memRespIn;

    int errors = 0;
    int errBase = 0;
    int testNum = 0;
    int failedTests = 0;
    int reqCount = 0;
    logic firstCycle = 1'b0;      // high over the request's first edge
    logic expectHit = 1'b0;
    logic expectMiss = 1'b0;
    logic cmpValid = 1'b0;
    cachePkg::wordT cmpGot;
    cachePkg::wordT cmpExp;
    string cmpName;
    cachePkg::wordT refMem [logic [31:0]]; // every stored word

    always #2 CLK = ~CLK;

    dcacheTop dut0 (
        .CLK(CLK),
        .nRST(nRST),
        .dpReqIn(dpReqIn),
        .dpRespOut(dpRespOut),
        .memReqOut(memReqOut),
        .memRespIn(memRespIn)
    );

    memModel #(.fillPattern(fillPattern)) mem0 (
        .CLK(CLK),
        .nRST(nRST),
        .req(memReqOut),
        .resp(memRespIn)
    );

    assert property (@(posedge CLK) disable iff (!nRST) cmpValid |-> cmpGot == cmpExp)
    else begin
        $display("Fail %0t %s got %h expected %h", $time, cmpName, cmpGot, cmpExp);
        errors++;
    end

    assert property (@(posedge CLK) disable iff (!nRST) firstCycle && expectHit |-> dpRespOut.dhit)
    else begin
        $display("Fail %0t dhit got 0 expected 1", $time);
        errors++;
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        firstCycle && expectMiss |-> !dpRespOut.dhit)
    else begin
        $display("Fail %0t dhit got 1 expected 0", $time);
        errors++;
    end

    assert property (@(posedge CLK) disable iff (!nRST) dpRespOut.flushed |-> !memReqOut.dWEN)
    else begin
        $display("Fail %0t dWEN got 1 expected 0", $time);
        errors++;
    end

    assert property (@(posedge CLK) !nRST |-> !(dpRespOut.dhit || dpRespOut.flushed
        || memReqOut.dREN || memReqOut.dWEN))
    else begin
        $display("Fail %0t dhit/flushed/dREN/dWEN got %b expected 0000", $time,
            {dpRespOut.dhit, dpRespOut.flushed, memReqOut.dREN, memReqOut.dWEN});
        errors++;
    end

    // tag | index | word | byte
    function automatic logic [31:0] blockAddr(int tag, int index, int word);
        return {tag[25:0], index[2:0], word[0], 2'b00};
    endfunction

    task automatic compare(string name, cachePkg::wordT got, cachePkg::wordT exp);
        @(negedge CLK);
        cmpName = name;
        cmpGot = got;
        cmpExp = exp;
        cmpValid = 1'b1;
        @(negedge CLK);
        cmpValid = 1'b0;
    endtask

    task automatic access(logic wr, logic [31:0] addr, cachePkg::wordT data, logic [1:0] mode,
                          output cachePkg::wordT loadOut);
        @(negedge CLK);
        dpReqIn.readEn = ~wr;
        dpReqIn.writeEn = wr;
        dpReqIn.addr.raw = addr;
        dpReqIn.store = data;
        expectHit = (mode == hitNow);
        expectMiss = (mode == missNow);
        firstCycle = 1'b1;
        reqCount++;
        #1;
        while (!dpRespOut.dhit) begin
            @(negedge CLK);
            firstCycle = 1'b0;
            #1;
        end
        loadOut = dpRespOut.load;
        @(negedge CLK);   // completing edge has passed
        dpReqIn.readEn = 1'b0;
        dpReqIn.writeEn = 1'b0;
        firstCycle = 1'b0;
        expectHit = 1'b0;
        expectMiss = 1'b0;
    endtask

    task automatic readCheck(logic [31:0] addr, logic [1:0] mode);
        cachePkg::wordT got;
        cachePkg::wordT exp;
        exp = refMem.exists(addr) ? refMem[addr] : (addr ^ fillPattern);
        access(1'b0, addr, '0, mode, got);
        compare($sformatf("load@%h", addr), got, exp);
    endtask

    task automatic writeWord(logic [31:0] addr, cachePkg::wordT data, logic [1:0] mode);
        cachePkg::wordT ignored;
        refMem[addr] = data;
        access(1'b1, addr, data, mode, ignored);
    endtask

    task automatic finishTest(string name);
        testNum++;
        if (errors != errBase) begin
            failedTests++;
        end
        $display("test %0d %s: %s", testNum, name, (errors == errBase) ? "ok" : "errors");
        errBase = errors;
    endtask

    // budget grows with every request issued
    initial begin
        int cycles = 0;
        while (cycles <= cyclesPerReq * (reqCount + 1)) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: the DUT did not finish within %0d cycles per request", cyclesPerReq);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        int logBase;
        void'($urandom(88));
        nRST = 1'b0;
        dpReqIn = '0;
        repeat (5) @(negedge CLK);
        nRST = 1'b1;

        readCheck(blockAddr(1, 2, 1), missNow);
        finishTest("read miss");

        readCheck(blockAddr(1, 2, 0), hitNow);
        finishTest("repeat read");

        writeWord(blockAddr(1, 2, 0), 32'h1357_9BDF, hitNow);
        readCheck(blockAddr(1, 2, 0), hitNow);
        writeWord(blockAddr(2, 5, 1), 32'h2468_ACE0, missNow); // allocate on store
        readCheck(blockAddr(2, 5, 1), hitNow);
        readCheck(blockAddr(2, 5, 0), hitNow);
        finishTest("write then read");

        readCheck(blockAddr(3, 4, 0), missNow);
        readCheck(blockAddr(4, 4, 0), missNow);
        readCheck(blockAddr(3, 4, 1), hitNow);
        readCheck(blockAddr(5, 4, 0), missNow); // B is lru here
        readCheck(blockAddr(3, 4, 0), hitNow);
        readCheck(blockAddr(4, 4, 1), missNow);
        finishTest("lru replacement");

        writeWord(blockAddr(6, 6, 0), 32'hD00D_0000, missNow);
        writeWord(blockAddr(6, 6, 1), 32'hD00D_0001, hitNow);
        writeWord(blockAddr(7, 6, 0), 32'hE00E_0000, missNow);
        logBase = mem0.logAddr.size();
        writeWord(blockAddr(8, 6, 1), 32'hF00F_0001, missNow);
        compare("log length", 32'(mem0.logAddr.size() - logBase), 32'd2);
        for (int w = 0; w < 2; w++) begin
            addr = blockAddr(6, 6, w);
            compare("log addr", mem0.logAddr[logBase + w], addr);
            compare("log data", mem0.logData[logBase + w], refMem[addr]);
        end
        readCheck(blockAddr(6, 6, 0), anyTime);
        readCheck(blockAddr(6, 6, 1), anyTime);
        finishTest("dirty eviction");

        for (int i = 0; i < 12; i++) begin
            addr = blockAddr(10 + int'($urandom % 4), int'($urandom % 8), int'($urandom % 2));
            writeWord(addr, $urandom, anyTime);
        end
        @(negedge CLK);
        dpReqIn.halt = 1'b1;   // held to the end
        reqCount++;
        #1;
        while (!dpRespOut.flushed) begin
            @(negedge CLK);
            #1;
        end
        foreach (refMem[a]) begin
            compare($sformatf("mem@%h", a),
                mem0.written[a[11:2]] ? mem0.mem[a[11:2]] : (a ^ fillPattern), refMem[a]);
        end
        finishTest("halt flush");

        $display("%0d tests, %0d failed, %0d check errors", testNum, failedTests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/memModel.sv */
`timescale 1ns/1ps

module memModel #(
    parameter logic [31:0] fillPattern = 32'h0
) (
    input  logic CLK,
    input  logic nRST,
    input  busPkg::memReq req,
    output busPkg::memResp resp
);
    cachePkg::wordT mem [1024];   // 4 KB window
    logic written [1024];
    logic [9:0] slot;
    logic active;
    logic [1:0] waitLeft;         // wait cycles left on this transfer
    logic [31:0] logAddr [$];
    cachePkg::wordT logData [$];

    assign active = req.dREN || req.dWEN;
    assign slot = req.addr.raw[11:2];
    assign resp.dwait = active && (waitLeft != 2'd0);
    assign resp.load = written[slot] ? mem[slot] : (req.addr.raw ^ fillPattern);

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            waitLeft <= 2'd0;
            for (int i = 0; i < 1024; i++) begin
                written[i] <= 1'b0;
            end
        end else begin
            if (resp.dwait) begin
                waitLeft <= waitLeft - 2'd1;
            end else begin
                waitLeft <= 2'($urandom % 4); // drawn for the next transfer
            end
            if (req.dWEN && !resp.dwait) begin
                mem[slot] <= req.store;
                written[slot] <= 1'b1;
                logAddr.push_back(req.addr.raw);
                logData.push_back(req.store);
            end
        end
    end

endmodule

/* common/busPkg.sv */
package busPkg;

    // datapath side
    typedef struct packed {
        logic readEn;
        logic writeEn;
        logic halt;
        cachePkg::cacheAddr addr;
        cachePkg::wordT store;
    } dpReq;

    typedef struct packed {
        logic dhit;
        logic flushed;
        cachePkg::wordT load;
    } dpResp;

    // memory side
    typedef struct packed {
        logic dREN;
        logic dWEN;
        cachePkg::cacheAddr addr;
        cachePkg::wordT store;
    } memReq;

    typedef struct packed {
        logic dwait;
        cachePkg::wordT load;
    } memResp;

endpackage

/* common/cachePkg.sv */
package cachePkg;

    localparam int numSets = 8;

    typedef logic [31:0] wordT;
    typedef logic [25:0] tagT;
    typedef logic [2:0] indexT;

    // tag | index | word | byte
    typedef struct packed {
        tagT tag;
        indexT index;
        logic wordSel;
        logic [1:0] byteOff;
    } addrFields;

    typedef union packed {
        wordT raw;
        addrFields f;
    } cacheAddr;

    typedef struct packed {
        logic valid;
        logic dirty;
        tagT tag;
        wordT [1:0] words;
    } cacheFrame;

    typedef struct packed {
        logic we;          // word write
        indexT index;
        logic wordSel;
        wordT data;
        logic setValid;    // also loads newTag
        logic setDirty;
        logic clearDirty;
        tagT newTag;
    } wayOp;

endpackage

/* dcache/cacheController.sv */
`timescale 1ns/1ps

module cacheController (
    input  logic CLK,
    input  logic nRST,
    input  busPkg::dpReq req,
    output busPkg::dpResp resp,
    output busPkg::memReq memOut,
    input  busPkg::memResp memIn,
    output cachePkg::indexT readIndex,
    output cachePkg::tagT lookupTag,
    output cachePkg::wayOp [1:0] wayOps,
    input  logic hitWay,
    input  logic victimWay,
    input  logic [1:0] hits,
    input  cachePkg::wordT hitWord,
    input  cachePkg::cacheFrame victim,
    output logic touch,
    output logic touchWay,
    output logic wordSel
);
    typedef enum logic [2:0] {
        IDLE,
        WB0,
        WB1,
        FETCH1,
        FETCH2,
        FLUSH,
        DONE
    } stateT;

    stateT state;
    stateT nextState;
    cachePkg::cacheAddr missAddr;
    cachePkg::wordT missStore;
    logic missWrite;
    logic latchReq;
    logic flushMode;
    logic [3:0] sweepPtr;   // {way, set}
    logic [3:0] nextSweep;
    logic lastFrame;
    logic wbSel;
    logic fillSel;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            flushMode <= 1'b0;
            sweepPtr <= '0;
            missWrite <= 1'b0;
        end else begin
            state <= nextState;
            sweepPtr <= nextSweep;
            if (state == IDLE && req.halt) begin
                flushMode <= 1'b1;
            end
            if (latchReq) begin
                missWrite <= req.writeEn;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (latchReq) begin
            missAddr <= req.addr;
            missStore <= req.store;
        end
    end

    // request fields go straight through while idle
    assign readIndex = (state == IDLE) ? req.addr.f.index
                     : flushMode ? sweepPtr[2:0] : missAddr.f.index;
    assign lookupTag = (state == IDLE) ? req.addr.f.tag : missAddr.f.tag;
    assign wordSel = (state == IDLE) ? req.addr.f.wordSel : missAddr.f.wordSel;

    assign lastFrame = (sweepPtr == 4'hF);
    assign wbSel = (state == WB1);
    assign fillSel = missAddr.f.wordSel ^ (state == FETCH2); // requested word first

    always_comb begin
        nextState = state;
        nextSweep = sweepPtr;
        latchReq = 1'b0;
        touch = 1'b0;
        touchWay = hitWay;
        memOut = '0;
        wayOps = '0;
        for (int i = 0; i < 2; i++) begin
            wayOps[i].index = readIndex;
        end
        resp = '0;
        resp.flushed = (state == DONE);
        resp.load = (state == FETCH2) ? victim.words[missAddr.f.wordSel] : hitWord;

        case (state)
            IDLE: begin
                if (req.halt) begin
                    nextState = FLUSH;
                end else if (req.readEn || req.writeEn) begin
                    if (|hits) begin
                        resp.dhit = 1'b1;
                        touch = 1'b1;
                        if (req.writeEn) begin
                            wayOps[hitWay].we = 1'b1;
                            wayOps[hitWay].wordSel = req.addr.f.wordSel;
                            wayOps[hitWay].data = req.store;
                            wayOps[hitWay].setDirty = 1'b1;
                        end
                    end else begin
                        latchReq = 1'b1;
                        nextState = (victim.valid && victim.dirty) ? WB0 : FETCH1;
                    end
                end
            end
            WB0, WB1: begin
                memOut.dWEN = 1'b1;
                memOut.addr.f.tag = victim.tag;
                memOut.addr.f.index = readIndex;
                memOut.addr.f.wordSel = wbSel;
                memOut.store = victim.words[wbSel];
                if (!memIn.dwait) begin
                    if (state == WB0) begin
                        nextState = WB1;
                    end else if (flushMode) begin
                        wayOps[victimWay].clearDirty = 1'b1;
                        nextSweep = sweepPtr + 4'd1;
                        nextState = lastFrame ? DONE : FLUSH;
                    end else begin
                        nextState = FETCH1;
                    end
                end
            end
            FETCH1, FETCH2: begin
                memOut.dREN = 1'b1;
                memOut.addr.raw = {missAddr.raw[31:3], fillSel, 2'b00};
                if (!memIn.dwait) begin
                    wayOps[victimWay].we = 1'b1;
                    wayOps[victimWay].wordSel = fillSel;
                    wayOps[victimWay].data = memIn.load;
                    if (state == FETCH1) begin
                        if (missWrite) begin
                            wayOps[victimWay].data = missStore; // store replaces fetched word
                        end
                        nextState = FETCH2;
                    end else begin
                        wayOps[victimWay].setValid = 1'b1;
                        wayOps[victimWay].newTag = missAddr.f.tag;
                        wayOps[victimWay].setDirty = missWrite;
                        wayOps[victimWay].clearDirty = ~missWrite;
                        resp.dhit = 1'b1;
                        touch = 1'b1;
                        touchWay = victimWay;
                        nextState = IDLE;
                    end
                end
            end
            FLUSH: begin
                if (victimWay != sweepPtr[3]) begin
                    touch = 1'b1;
                    touchWay = ~sweepPtr[3]; // swept way shows on the victim port next cycle
                end else if (victim.valid && victim.dirty) begin
                    nextState = WB0;
                end else begin
                    nextSweep = sweepPtr + 4'd1;
                    nextState = lastFrame ? DONE : FLUSH;
                end
            end
            DONE: begin
                nextState = DONE; // held until reset
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

endmodule

/* dcache/cacheWay.sv */
`timescale 1ns/1ps

module cacheWay (
    input  logic CLK,
    input  logic nRST,
    input  cachePkg::indexT readIndex,
    input  cachePkg::tagT lookupTag,
    input  cachePkg::wayOp op,
    output cachePkg::cacheFrame frame,
    output logic hit
);
    logic [cachePkg::numSets-1:0] valid;
    logic [cachePkg::numSets-1:0] dirty;
    cachePkg::tagT tags [cachePkg::numSets];
    cachePkg::wordT [1:0] data [cachePkg::numSets];

    // status bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (op.setValid) begin
                valid[op.index] <= 1'b1;
            end
            if (op.setDirty) begin
                dirty[op.index] <= 1'b1;
            end else if (op.clearDirty) begin
                dirty[op.index] <= 1'b0;
            end
        end
    end

    // tag and block storage
    always_ff @(posedge CLK) begin
        if (op.we) begin
            data[op.index][op.wordSel] <= op.data;
        end
        if (op.setValid) begin
            tags[op.index] <= op.newTag;
        end
    end

    always_comb begin
        frame.valid = valid[readIndex];
        frame.dirty = dirty[readIndex];
        frame.tag = tags[readIndex];
        frame.words = data[readIndex];
    end

    assign hit = frame.valid && (frame.tag == lookupTag);

endmodule

/* dcache/dcacheTop.sv */
`timescale 1ns/1ps

module dcacheTop (
    input  logic CLK,
    input  logic nRST,
    input  busPkg::dpReq dpReqIn,
    output busPkg::dpResp dpRespOut,
    output busPkg::memReq memReqOut,
    input  busPkg::memResp memRespIn
);
    cachePkg::indexT readIndex;
    cachePkg::tagT lookupTag;
    cachePkg::wayOp [1:0] wayOps;
    cachePkg::cacheFrame [1:0] frames;
    cachePkg::cacheFrame victim;
    cachePkg::wordT hitWord;
    logic [1:0] hits;
    logic hitWay;
    logic victimWay;
    logic touch;
    logic touchWay;
    logic wordSel;

    cacheController ctrl0 (
        .CLK(CLK),
        .nRST(nRST),
        .req(dpReqIn),
        .resp(dpRespOut),
        .memOut(memReqOut),
        .memIn(memRespIn),
        .readIndex(readIndex),
        .lookupTag(lookupTag),
        .wayOps(wayOps),
        .hitWay(hitWay),
        .victimWay(victimWay),
        .hits(hits),
        .hitWord(hitWord),
        .victim(victim),
        .touch(touch),
        .touchWay(touchWay),
        .wordSel(wordSel)
    );

    for (genvar g = 0; g < 2; g++) begin : gWay
        cacheWay way (
            .CLK(CLK),
            .nRST(nRST),
            .readIndex(readIndex),
            .lookupTag(lookupTag),
            .op(wayOps[g]),
            .frame(frames[g]),
            .hit(hits[g])
        );
    end

    wayReplace repl0 (
        .CLK(CLK),
        .nRST(nRST),
        .readIndex(readIndex),
        .frames(frames),
        .hits(hits),
        .wordSel(wordSel),
        .touch(touch),
        .touchWay(touchWay),
        .hitWay(hitWay),
        .hitWord(hitWord),
        .victimWay(victimWay),
        .victim(victim)
    );

endmodule

/* dcache/wayReplace.sv */
`timescale 1ns/1ps

module wayReplace (
    input  logic CLK,
    input  logic nRST,
    input  cachePkg::indexT readIndex,
    input  cachePkg::cacheFrame [1:0] frames,
    input  logic [1:0] hits,
    input  logic wordSel,
    input  logic touch,
    input  logic touchWay,
    output logic hitWay,
    output cachePkg::wordT hitWord,
    output logic victimWay,
    output cachePkg::cacheFrame victim
);
    logic [cachePkg::numSets-1:0] lru; // holds the least recent way per set

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru <= '0;
        end else if (touch) begin
            lru[readIndex] <= ~touchWay; // other way becomes lru
        end
    end

    assign hitWay = hits[1] & ~hits[0];
    assign hitWord = frames[hitWay].words[wordSel];

    assign victimWay = lru[readIndex];
    assign victim = frames[victimWay];

endmodule

/* list.f */
common/cachePkg.sv
common/busPkg.sv
dcache/cacheWay.sv
dcache/wayReplace.sv
dcache/cacheController.sv
dcache/dcacheTop.sv
bench/memModel.sv
bench/dcacheTb.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert --top-module dcacheTb -f list.f -o simv > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 ; cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
